// ==== filelist.f ====
design/mole_pkg.sv
design/button_edges.sv
design/mole_spawner.sv
design/whack_game_fsm.sv
design/mole_display.sv
design/whack_a_mole_top.sv
dv/whack_a_mole_checker.sv
dv/whack_a_mole_props.sv
dv/whack_a_mole_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = whack_a_mole_tb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_TEXT  = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/whack_a_mole_tb.sv ====
`timescale 1ns/10ps

module whack_a_mole_tb import mole_pkg::*; ();

    logic                 clk;
    logic                 reset;
    logic [num_holes-1:0] buttons;
    logic [num_holes-1:0] moles;
    logic [score_w-1:0]   score;
    logic [lives_w-1:0]   lives;
    logic [score_w-1:0]   high_score;
    game_state_t          state;

    typedef enum int {act_start, act_hit, act_wrong, act_miss, act_restart} action_t;

    // One row of the stimulus table
    typedef struct {
        action_t     action;
        int          score;                       // Expected after the action
        int          lives;
        game_state_t state;
        string       name;
    } step_t;

    localparam int mole_limit  = 72 + 10;         // Longest spawn delay plus display lag
    localparam int step_cycles = 72 + 200 + 20;   // Worst case length of one step

    step_t                      steps [$];
    int                         seed = 29;
    int                         cycle_limit = 0;  // Set once the table is built
    int                         cycle_count = 0;
    int                         exp_high = 0;     // Best score seen so far
    logic [score_w+lives_w+1:0] snap;             // Outputs before an action

    whack_a_mole_top uut (
        .clk        (clk),
        .reset      (reset),
        .buttons    (buttons),
        .moles      (moles),
        .score      (score),
        .lives      (lives),
        .high_score (high_score),
        .state      (state)
    );

    whack_a_mole_checker u_chk (
        .clk        (clk),
        .reset      (reset),
        .moles      (moles),
        .score      (score),
        .lives      (lives),
        .high_score (high_score),
        .state      (state)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;                        // 8 ns period
        end
    end

    // Watchdog
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles, the test sequence did not finish", cycle_count);
        $display("tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #1;                                       // Drive and sample just after the edge
    endtask

    function automatic logic [score_w+lives_w+1:0] outputs_now();
        return {score, lives, state};
    endfunction

    // Window shrinks one step per full ten points down to a floor
    function automatic int window_for(input int points);
        int w;
        w = hit_window_base - hit_window_step * (points / 10);
        return (w < hit_window_min) ? hit_window_min : w;
    endfunction

    task automatic add_step(input action_t a, input int sc, input int lv,
                            input game_state_t st, input string nm);
        step_t s;
        s.action = a;
        s.score  = sc;
        s.lives  = lv;
        s.state  = st;
        s.name   = nm;
        steps.push_back(s);
    endtask

    task automatic press_button(input int idx);
        buttons = num_holes'(1 << idx);
        repeat (4) next_cycle();                  // Held 4 cycles
        buttons = '0;
    endtask

    task automatic wait_for_mole(input string name, output int hole, output bit found);
        int n;
        n    = 0;
        hole = 0;
        while (moles == '0 && n < mole_limit) begin
            next_cycle();
            n++;
        end
        found = (moles != '0);
        if (!found) begin
            u_chk.report_problem(name, $sformatf("no mole lit within %0d cycles", mole_limit));
        end
        for (int b = 0; b < num_holes; b++) begin
            if (moles == num_holes'(1 << b)) hole = b;
        end
    endtask

    // Waits for score, lives or state to move away from the snapshot
    task automatic wait_for_update(input string name, input int limit,
                                   output int cycles, output bit changed);
        cycles = 0;
        while (outputs_now() == snap && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        changed = (outputs_now() != snap);
        if (!changed) begin
            u_chk.report_problem(name, $sformatf("no score, lives or state change in %0d cycles",
                                                 limit));
        end
    endtask

    task automatic wait_for_dark(input string name);
        int n;
        n = 0;
        while (moles != '0 && n < 4) begin
            next_cycle();
            n++;
        end
        u_chk.check_dark(name);
    endtask

    // Every mole must toggle at least once within the longest blink period
    task automatic watch_blink(input string name);
        logic [num_holes-1:0] prev;
        logic [num_holes-1:0] toggled;
        prev    = moles;
        toggled = '0;
        repeat (80 + 4) begin
            next_cycle();
            toggled = toggled | (moles ^ prev);
            prev    = moles;
        end
        u_chk.compare_field(name, "blink toggles", (1 << num_holes) - 1, int'(toggled));
    endtask

    ////////////////////////////////////////////////////////////
    // One table row
    ////////////////////////////////////////////////////////////
    task automatic run_step(input step_t s);
        int hole;
        int target;
        int cycles;
        int window;
        bit ok;
        case (s.action)
            act_start, act_restart: begin
                snap = outputs_now();
                press_button(0);
                wait_for_update(s.name, 20, cycles, ok);
            end
            act_hit, act_wrong: begin
                wait_for_mole(s.name, hole, ok);
                if (ok) begin
                    target = hole;
                    if (s.action == act_wrong) begin   // Any other hole
                        target = (hole + 1 + int'($unsigned($random(seed)) % 3)) % num_holes;
                    end
                    snap = outputs_now();
                    press_button(target);
                    wait_for_update(s.name, 20, cycles, ok);
                end
            end
            act_miss: begin
                wait_for_mole(s.name, hole, ok);
                if (ok) begin
                    window = window_for(s.score);      // Score does not move on a miss
                    snap   = outputs_now();
                    wait_for_update(s.name, window + 8, cycles, ok);
                    if (ok) begin
                        u_chk.check_range(s.name, "window cycles", window - 4, window + 4, cycles);
                    end
                end
            end
            default: ;
        endcase
        if (s.action != act_start && s.state != end_screen) begin
            wait_for_dark(s.name);                     // Mole cleared or idle
        end
        if (s.state == end_screen && s.score > exp_high) begin
            exp_high = s.score;
        end
        u_chk.check_outputs(s.name, s.score, s.lives, s.state, exp_high);
        if (s.state == end_screen) begin
            watch_blink(s.name);
        end
    endtask

    initial begin
        buttons = '0;
        reset   = 1'b1;
        add_step(act_start, 0, 3, play, "first_start");
        for (int i = 1; i <= 12; i++) begin
            add_step(act_hit, i, 3, play, $sformatf("hit_%0d", i));
        end
        add_step(act_miss, 12, 2, play, "miss_at_12");
        add_step(act_wrong, 12, 1, play, "wrong_button");
        add_step(act_miss, 12, 0, end_screen, "last_life");
        add_step(act_restart, 12, 0, idle, "leave_end");
        add_step(act_start, 0, 3, play, "second_start");
        add_step(act_hit, 1, 3, play, "second_hit");
        add_step(act_wrong, 1, 2, play, "second_wrong_1");
        add_step(act_wrong, 1, 1, play, "second_wrong_2");
        add_step(act_miss, 1, 0, end_screen, "second_end");   // Lower score keeps the best
        add_step(act_restart, 1, 0, idle, "final_restart");
        cycle_limit = steps.size() * step_cycles * 3 / 2;

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();
        u_chk.check_outputs("after_reset", 0, 0, idle, 0);
        u_chk.check_dark("after_reset");

        foreach (steps[i]) begin
            run_step(steps[i]);
        end

        $display("Error counts: %0d value mismatches, %0d other failures",
                 u_chk.value_errors, u_chk.other_errors);
        if (u_chk.value_errors + u_chk.other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== dv/whack_a_mole_props.sv ====
`timescale 1ns/10ps

module whack_a_mole_props import mole_pkg::*; (
    input logic               clk,
    input logic               reset,
    input game_state_t        state,
    input logic               lit,
    input spawn_t             spawn,
    input logic [lives_w-1:0] lives,
    input logic [score_w-1:0] score
);

    // No second mole arrives while one is up
    a_one_mole: assert property (@(posedge clk) disable iff (reset)
        lit |-> !spawn.valid)
        else $error("second mole arrived while one is lit");

    a_spawn_pulse: assert property (@(posedge clk) disable iff (reset)
        spawn.valid |=> !spawn.valid)
        else $error("spawn valid wider than one cycle");

    // Lives only go down while playing
    a_lives_fall: assert property (@(posedge clk) disable iff (reset)
        (state == play) |=> (lives <= $past(lives)))
        else $error("lives went up during play");

    a_score_no_wrap: assert property (@(posedge clk) disable iff (reset)
        (state == play) |=> (score >= $past(score)))     // A wrap would show as a drop
        else $error("score overflowed its width");

endmodule

bind whack_game_fsm whack_a_mole_props u_props (
    .clk   (clk),
    .reset (reset),
    .state (state),
    .lit   (lit),
    .spawn (spawn),
    .lives (lives),
    .score (score)
);

// ==== dv/whack_a_mole_checker.sv ====
`timescale 1ns/10ps

module whack_a_mole_checker import mole_pkg::*; (
    input logic                 clk,
    input logic                 reset,
    input logic [num_holes-1:0] moles,
    input logic [score_w-1:0]   score,
    input logic [lives_w-1:0]   lives,
    input logic [score_w-1:0]   high_score,
    input game_state_t          state
);

    int          value_errors = 0;          // Wrong values seen
    int          other_errors = 0;          // Timeouts and watch failures
    game_state_t prev_state;

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic compare_field(input string name, input string field,
                                 input int expected, input int actual);
        if (actual != expected) begin
            value_errors++;
            $display("Fail %s: %s expected %0d actual %0d", name, field, expected, actual);
        end
    endtask

    task automatic check_range(input string name, input string field,
                               input int lo, input int hi, input int actual);
        if (actual < lo || actual > hi) begin
            value_errors++;
            $display("Fail %s: %s expected %0d to %0d actual %0d", name, field, lo, hi, actual);
        end
    endtask

    task automatic report_problem(input string name, input string what);
        other_errors++;
        $display("Error in %s: %s", name, what);
    endtask

    // All game outputs against the expected row
    task automatic check_outputs(input string name, input int exp_score, input int exp_lives,
                                 input game_state_t exp_state, input int exp_high);
        compare_field(name, "score", exp_score, int'(score));
        compare_field(name, "lives", exp_lives, int'(lives));
        compare_field(name, "state", int'(exp_state), int'(state));
        compare_field(name, "high_score", exp_high, int'(high_score));
    endtask

    task automatic check_dark(input string name);
        compare_field(name, "moles", 0, int'(moles));
    endtask

    ////////////////////////////////////////////////////////////
    // Cycle by cycle watch on the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!reset && state == play && !$onehot0(moles)) begin
            report_problem("play watch", "more than one mole lit at once");
        end
        // Display lags the state by one register
        if (!reset && state == idle && prev_state == idle && moles != '0) begin
            report_problem("idle watch", "moles still lit in idle");
        end
        prev_state <= state;
    end

endmodule

// ==== design/whack_a_mole_top.sv ====
`timescale 1ns/10ps

module whack_a_mole_top import mole_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [num_holes-1:0] buttons,     // Player buttons
    output logic [num_holes-1:0] moles,       // Mole LEDs
    output logic [score_w-1:0]   score,
    output logic [lives_w-1:0]   lives,
    output logic [score_w-1:0]   high_score,  // Best score since reset
    output game_state_t          state
);

    ////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////
    press_t     press;                         // Edge strobes
    logic       spawn_req;                     // FSM asks for a mole
    spawn_t     spawn;                         // Spawner answer
    game_view_t view;                          // FSM to display

    // Button producer
    button_edges u_edges (
        .clk     (clk),
        .reset   (reset),
        .buttons (buttons),
        .press   (press)
    );

    // Random hole and delay
    mole_spawner u_spawner (
        .clk       (clk),
        .reset     (reset),
        .spawn_req (spawn_req),
        .spawn     (spawn)
    );

    whack_game_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .press      (press),
        .spawn      (spawn),
        .spawn_req  (spawn_req),
        .view       (view),
        .score      (score),
        .lives      (lives),
        .high_score (high_score)
    );

    // LED consumer
    mole_display u_display (
        .clk   (clk),
        .reset (reset),
        .view  (view),
        .moles (moles)
    );

    assign state = view.state;                 // Game state for the outside

endmodule

// ==== design/mole_display.sv ====
`timescale 1ns/10ps

module mole_display import mole_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  game_view_t           view,      // Game state from the FSM
    output logic [num_holes-1:0] moles      // One LED per hole
);

    logic [blink_w-1:0]   blink_cnt [num_holes];   // Per hole toggle counters
    logic [num_holes-1:0] hole_onehot;

    assign hole_onehot = {{(num_holes-1){1'b0}}, 1'b1} << view.hole;

    ////////////////////////////////////////////////////////////
    // Output register and blink counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            moles <= '0;
            for (int i = 0; i < num_holes; i++) begin
                blink_cnt[i] <= '0;
            end
        end else begin
            case (view.state)
                play: begin
                    moles <= view.lit ? hole_onehot : '0;  // Single lit mole
                    for (int i = 0; i < num_holes; i++) begin
                        blink_cnt[i] <= '0;     // Fresh start for the end screen
                    end
                end

                end_screen: begin
                    // Each mole dances at its own rate
                    for (int i = 0; i < num_holes; i++) begin
                        if (blink_cnt[i] == blink_period[i] - 1'b1) begin
                            blink_cnt[i] <= '0;
                            moles[i]     <= ~moles[i];
                        end else begin
                            blink_cnt[i] <= blink_cnt[i] + 1'b1;
                        end
                    end
                end

                default: begin
                    moles <= '0;                // Idle with all moles dark
                    for (int i = 0; i < num_holes; i++) begin
                        blink_cnt[i] <= '0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== design/whack_game_fsm.sv ====
`timescale 1ns/10ps

module whack_game_fsm import mole_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  press_t             press,        // Button strobes
    input  spawn_t             spawn,        // New mole from the spawner
    output logic               spawn_req,    // One cycle, asks for a mole
    output game_view_t         view,         // To the display
    output logic [score_w-1:0] score,
    output logic [lives_w-1:0] lives,
    output logic [score_w-1:0] high_score
);

    game_state_t         state;
    logic                lit;                // Mole up and window running
    hole_t               hole;               // Lit hole
    logic [window_w-1:0] window_cnt;         // Cycles left in the hit window
    logic [window_w-1:0] window_load;
    logic [num_holes-1:0] hole_mask;
    logic                hit;
    logic                wrong;
    logic                expired;
    logic                lose_life;

    ////////////////////////////////////////////////////////////
    // Hit window length from the current score
    ////////////////////////////////////////////////////////////
    always_comb begin
        int win;
        win = hit_window_base - hit_window_step * (int'(score) / 10);
        if (win < hit_window_min) begin
            win = hit_window_min;            // Floor
        end
        window_load = window_w'(win - 1);    // Counts down to zero
    end

    // Press decode against the lit hole
    assign hole_mask = {{(num_holes-1){1'b0}}, 1'b1} << hole;
    assign hit       = lit && (press.mask == hole_mask);   // Only the right button
    assign wrong     = lit && press.any && !hit;           // Anything else pressed
    assign expired   = lit && !press.any && (window_cnt == '0);
    assign lose_life = wrong || expired;

    ////////////////////////////////////////////////////////////
    // Game state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= idle;
            score      <= '0;
            lives      <= '0;
            high_score <= '0;
            lit        <= 1'b0;
            hole       <= '0;
            window_cnt <= '0;
            spawn_req  <= 1'b0;
        end else begin
            spawn_req <= 1'b0;               // Pulse by default
            case (state)
                idle: begin
                    if (press.any) begin     // Any button starts a game
                        state     <= play;
                        score     <= '0;
                        lives     <= lives_w'(start_lives);
                        lit       <= 1'b0;
                        spawn_req <= 1'b1;
                    end
                end

                play: begin
                    if (!lit) begin
                        // Presses ignored until a mole shows
                        if (spawn.valid) begin
                            lit        <= 1'b1;
                            hole       <= spawn.hole;
                            window_cnt <= window_load;
                        end
                    end else if (hit) begin
                        lit       <= 1'b0;
                        spawn_req <= 1'b1;
                        if (score != '1) begin
                            score <= score + 1'b1;    // Saturates at the top
                        end
                    end else if (lose_life) begin
                        lit   <= 1'b0;
                        lives <= lives - 1'b1;
                        if (lives == lives_w'(1)) begin
                            state <= end_screen;      // Last life gone
                            if (score > high_score) begin
                                high_score <= score;
                            end
                        end else begin
                            spawn_req <= 1'b1;        // Next mole
                        end
                    end else begin
                        window_cnt <= window_cnt - 1'b1;
                    end
                end

                end_screen: begin
                    if (press.any) begin
                        state <= idle;       // Back to idle with the score still shown
                    end
                end

                default: state <= idle;
            endcase
        end
    end

    // View straight from the registers
    assign view.state = state;
    assign view.lit   = lit;
    assign view.hole  = hole;

endmodule

// ==== design/mole_spawner.sv ====
`timescale 1ns/10ps

module mole_spawner import mole_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   spawn_req,               // Ask for the next mole
    output spawn_t spawn                    // Hole and strobe when delay is over
);

    ////////////////////////////////////////////////////////////
    // LFSR with taps x^8 + x^6 + x^5 + x^4 + 1
    ////////////////////////////////////////////////////////////
    logic [lfsr_w-1:0]  lfsr;
    logic [lfsr_w-1:0]  lfsr_next;
    logic               feedback;

    assign feedback  = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    assign lfsr_next = {lfsr[lfsr_w-2:0], feedback};

    ////////////////////////////////////////////////////////////
    // Countdown
    ////////////////////////////////////////////////////////////
    logic [delay_w-1:0] count;              // Cycles left before the strobe
    logic [delay_w-1:0] delay_load;
    logic               active;             // Countdown in progress
    hole_t              next_hole;
    hole_t              hole_q;             // Hole picked at request time

    // Delay field is bits 4:2 of the new value for 16 to 72 cycles
    // Loaded one short so the strobe lands on the last cycle
    assign delay_load = delay_w'(spawn_delay_min
                                 + spawn_delay_step * int'(lfsr_next[4:2]) - 1);
    assign next_hole  = lfsr_next[1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr   <= lfsr_seed;
            count  <= '0;
            active <= 1'b0;
        end else if (spawn_req) begin       // Restarts any running countdown
            lfsr   <= lfsr_next;
            count  <= delay_load;
            active <= 1'b1;
        end else if (active) begin
            if (count == '0) begin
                active <= 1'b0;             // Strobe goes out this cycle
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Hole held until the strobe goes out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hole_q <= '0;
        end else if (spawn_req) begin
            hole_q <= next_hole;
        end
    end

    assign spawn.valid = active && (count == '0);
    assign spawn.hole  = hole_q;

endmodule

// ==== design/button_edges.sv ====
`timescale 1ns/10ps

module button_edges import mole_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [num_holes-1:0] buttons,   // Raw, asynchronous to clk
    output press_t               press      // One cycle per rising edge
);

    logic [num_holes-1:0] sync_a;           // First synchronizer stage
    logic [num_holes-1:0] sync_b;           // Second synchronizer stage
    logic [num_holes-1:0] prev;             // Last sampled value
    logic [num_holes-1:0] rise;

    // High for the cycle where a button has just gone up
    assign rise = sync_b & ~prev;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_a     <= '0;
            sync_b     <= '0;
            prev       <= '0;
            press.mask <= '0;
            press.any  <= 1'b0;
        end else begin
            sync_a     <= buttons;
            sync_b     <= sync_a;
            prev       <= sync_b;
            press.mask <= rise;             // Strobe lands 3 edges after the button
            press.any  <= |rise;            // Start and restart only need this
        end
    end

endmodule

// ==== design/mole_pkg.sv ====
package mole_pkg;

    ////////////////////////////////////////////////////////////
    // Game sizes
    ////////////////////////////////////////////////////////////
    localparam int num_holes   = 4;                   // Holes and buttons
    localparam int score_w     = 7;                   // Score counter width
    localparam int lives_w     = 2;                   // Lives counter width
    localparam int start_lives = 3;                   // Lives at game start

    ////////////////////////////////////////////////////////////
    // Mole spawning
    ////////////////////////////////////////////////////////////
    localparam int lfsr_w = 8;
    localparam logic [lfsr_w-1:0] lfsr_seed = 8'd1;   // Any nonzero value works
    localparam int spawn_delay_min  = 16;             // Cycles before a mole at d = 0
    localparam int spawn_delay_step = 8;              // Extra cycles per unit of d
    localparam int delay_w = 7;                       // Holds up to 72 - 1

    ////////////////////////////////////////////////////////////
    // Hit window that shrinks every ten points
    ////////////////////////////////////////////////////////////
    localparam int hit_window_base = 200;             // Window at score 0
    localparam int hit_window_step = 16;              // Cut per full ten points
    localparam int hit_window_min  = 40;              // Never shorter than this
    localparam int window_w        = 8;               // Holds up to 200 - 1

    // End screen toggle periods with entry 0 for hole 0
    localparam int blink_w = 7;
    localparam logic [num_holes-1:0][blink_w-1:0] blink_period = {
        7'd80,                                        // Hole 3
        7'd60,                                        // Hole 2
        7'd40,                                        // Hole 1
        7'd20                                         // Hole 0
    };

    ////////////////////////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        idle       = 2'd0,                            // Waiting for a press
        play       = 2'd1,                            // Game running
        end_screen = 2'd2                             // Blinking moles and best score kept
    } game_state_t;

    typedef logic [1:0] hole_t;                       // Hole index

    // Button strobes from the edge detector
    typedef struct packed {
        logic                 any;                    // OR of all strobes
        logic [num_holes-1:0] mask;                   // One bit per button
    } press_t;

    // New mole from the spawner
    typedef struct packed {
        logic  valid;                                 // Single cycle strobe
        hole_t hole;
    } spawn_t;

    // What the display needs to know about the game
    typedef struct packed {
        game_state_t state;
        logic        lit;                             // A mole is up
        hole_t       hole;                            // Which one
    } game_view_t;

endpackage
